/* src/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [31:0] u32_t;               // PCs, targets and instruction words.
    typedef logic [31:0] phy_t;               // Physical address.
    typedef logic [1:0]  mat_t;               // Memory access type, bit 0 means cached.
    typedef logic [1:0]  plv_t;               // Privilege level.

    localparam u32_t RESET_PC = 32'h1c000000;

    localparam int unsigned BTB_IDX_W   = 6;  // PC bits 7 to 2.
    localparam int unsigned BTB_TAG_W   = 24; // PC bits 31 to 8.
    localparam int unsigned BTB_ENTRIES = 1 << BTB_IDX_W;

    typedef logic [BTB_IDX_W-1:0] btb_idx_t;
    typedef logic [BTB_TAG_W-1:0] btb_tag_t;

    localparam plv_t PLV_KERNEL = 2'd0;
    localparam plv_t PLV_USER   = 2'd3;

    localparam mat_t MAT_SUC = 2'd0;          // Strongly ordered uncached.
    localparam mat_t MAT_CC  = 2'd1;          // Coherent cached.

    typedef enum logic [5:0] {
        ECODE_NONE = 6'h00,
        ECODE_ADEF = 6'h08,                   // Fetch address misaligned.
        ECODE_TLBR = 6'h3f                    // TLB refill.
    } ecode_e;

    typedef enum logic [2:0] {
        IC_NOP = 3'd0,
        IC_R   = 3'd1
    } ic_op_e;

    typedef enum logic {
        IDLE = 1'b0,
        FILL = 1'b1
    } btb_state_e;

    typedef struct packed {
        logic valid;
        u32_t pc;                             // New fetch target.
        u32_t src_pc;                         // PC of the branch itself.
        logic taken;
    } wr_pc_req_t;

    typedef struct packed {
        logic valid;
        u32_t npc;
    } btb_predict_t;

    typedef struct packed {
        logic     plv0;
        logic     plv3;
        mat_t     mat;
        logic [2:0] pseg;
        logic [2:0] vseg;
    } dmw_t;

    typedef struct packed {
        logic crmd_da;
        logic crmd_pg;
        plv_t crmd_plv;
        mat_t crmd_datf;
        dmw_t dmw0;
        dmw_t dmw1;
        u32_t eentry;
    } csr_t;

    typedef struct packed {
        logic   valid;
        ecode_e ecode;
        u32_t   badv;
    } excp_pass_t;

    typedef struct packed {
        logic is_flush;
        u32_t pc;
        u32_t btb_pre;                        // Next PC chosen while this PC was fetched.
    } fetch1_fetch2_pass_t;

    typedef struct packed {
        logic       valid;
        u32_t       pc;
        u32_t       inst;
        u32_t       pred_npc;
        excp_pass_t excp;
    } inst_packet_t;

endpackage

/* src/addr_trans.sv */
`timescale 1ns/1ps

module addr_trans (
    input  cpu_pkg::u32_t       va,
    input  cpu_pkg::csr_t       rd_csr,
    output cpu_pkg::phy_t       pa,
    output cpu_pkg::mat_t       mat,
    output cpu_pkg::excp_pass_t excp
);

    import cpu_pkg::*;

    logic direct;
    logic dmw0_hit;
    logic dmw1_hit;
    logic misaligned;
    logic tlb_miss;

    function automatic logic dmw_match(dmw_t win, plv_t plv, u32_t addr);
        logic plv_ok;
        plv_ok = (plv == PLV_KERNEL && win.plv0) || (plv == PLV_USER && win.plv3);
        return plv_ok && (addr[31:29] == win.vseg);
    endfunction

    assign direct   = rd_csr.crmd_da && !rd_csr.crmd_pg;
    assign dmw0_hit = dmw_match(rd_csr.dmw0, rd_csr.crmd_plv, va);
    assign dmw1_hit = dmw_match(rd_csr.dmw1, rd_csr.crmd_plv, va);

    assign misaligned = (va[1:0] != 2'b00);
    assign tlb_miss   = !direct && !dmw0_hit && !dmw1_hit; // No TLB, so a miss always refills.

    always_comb begin
        pa  = va;
        mat = rd_csr.crmd_datf;
        if (!direct) begin
            if (dmw0_hit) begin                 // Window 0 has priority.
                pa  = {rd_csr.dmw0.pseg, va[28:0]};
                mat = rd_csr.dmw0.mat;
            end else if (dmw1_hit) begin
                pa  = {rd_csr.dmw1.pseg, va[28:0]};
                mat = rd_csr.dmw1.mat;
            end else begin
                mat = MAT_SUC;
            end
        end
    end

    always_comb begin
        excp.valid = misaligned || tlb_miss;
        excp.badv  = va;
        if (misaligned) begin
            excp.ecode = ECODE_ADEF;
        end else if (tlb_miss) begin
            excp.ecode = ECODE_TLBR;
        end else begin
            excp.ecode = ECODE_NONE;
        end
    end

    // A clean translation must always produce a defined address.
    always_comb begin
        pa_known: assert final (excp.valid || !$isunknown(pa))
            else $error("addr_trans: unknown pa for va %h", va);
    end

endmodule

/* src/btb.sv */
`timescale 1ns/1ps

module btb (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cpu_pkg::u32_t         btb_pc,
    input  logic                  btb_is_stall,
    input  cpu_pkg::wr_pc_req_t   train,
    output cpu_pkg::btb_predict_t btb_predict
);

    import cpu_pkg::*;

    logic     valid_q  [BTB_ENTRIES];
    btb_tag_t tag_q    [BTB_ENTRIES];
    u32_t     target_q [BTB_ENTRIES];

    btb_state_e state;
    btb_idx_t   fill_idx;

    btb_idx_t lk_idx;
    btb_idx_t tr_idx;
    btb_tag_t tr_tag;
    logic     tr_present;

    u32_t     look_pc_r;                       // PC whose entry is held below.
    logic     hit_valid_r;
    btb_tag_t hit_tag_r;
    u32_t     hit_target_r;

    assign lk_idx     = btb_pc[BTB_IDX_W+1:2];
    assign tr_idx     = train.src_pc[BTB_IDX_W+1:2];
    assign tr_tag     = train.src_pc[31:BTB_IDX_W+2];
    assign tr_present = valid_q[tr_idx] && (tag_q[tr_idx] == tr_tag);

    // Sweep the valid bits once after reset.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= FILL;
            fill_idx <= '0;
        end else if (state == FILL) begin
            fill_idx <= fill_idx + 1'b1;
            if (&fill_idx) begin
                state <= IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == FILL) begin
            valid_q[fill_idx] <= 1'b0;
        end else if (train.valid && train.taken) begin
            valid_q[tr_idx]  <= 1'b1;
            tag_q[tr_idx]    <= tr_tag;
            target_q[tr_idx] <= train.pc;
        end else if (train.valid && tr_present) begin
            valid_q[tr_idx]  <= 1'b0;            // Not taken any more, drop it.
        end
    end

    // Registered lookup, reads the old entry on a same-cycle write.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_valid_r <= 1'b0;
        end else if (!btb_is_stall) begin
            hit_valid_r <= (state == IDLE) && valid_q[lk_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!btb_is_stall) begin
            look_pc_r    <= btb_pc;
            hit_tag_r    <= tag_q[lk_idx];
            hit_target_r <= target_q[lk_idx];
        end
    end

    assign btb_predict.valid = hit_valid_r && (hit_tag_r == look_pc_r[31:BTB_IDX_W+2]);
    assign btb_predict.npc   = hit_target_r;

    // The registered lookup must not leak a prediction while the sweep runs.
    no_pred_in_fill: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == FILL) |-> !btb_predict.valid
    ) else $error("btb: prediction during FILL");

endmodule

/* src/fetch1.sv */
`timescale 1ns/1ps

module fetch1 (
    input  logic                         clk,
    input  logic                         rst_n,

    output logic                         btb_is_stall,
    output cpu_pkg::u32_t                btb_pc,
    input  cpu_pkg::btb_predict_t        btb_predict,

    input  cpu_pkg::wr_pc_req_t          ex_wr_pc_req,
    input  cpu_pkg::wr_pc_req_t          excp_wr_pc_req,

    input  cpu_pkg::csr_t                rd_csr,

    output logic [11:0]                  icache_idx,
    output cpu_pkg::ic_op_e              icache_op,
    output cpu_pkg::phy_t                icache_pa,
    output logic                         icache_is_cached,

    input  logic                         is_stall,
    input  logic                         is_flush,

    output cpu_pkg::fetch1_fetch2_pass_t pass_out,
    output cpu_pkg::excp_pass_t          excp_pass_out
);

    import cpu_pkg::*;

    u32_t       pc_r;
    u32_t       npc;
    phy_t       pa;
    mat_t       mat;
    excp_pass_t addr_excp;

    addr_trans u_addr_trans (
        .va     (pc_r),
        .rd_csr (rd_csr),
        .pa     (pa),
        .mat    (mat),
        .excp   (addr_excp)
    );

    // Writeback beats execute, execute beats the BTB.
    always_comb begin
        if (excp_wr_pc_req.valid) begin
            npc = excp_wr_pc_req.pc;
        end else if (ex_wr_pc_req.valid) begin
            npc = ex_wr_pc_req.pc;
        end else if (btb_predict.valid) begin
            npc = btb_predict.npc;              // Prediction belongs to pc_r.
        end else begin
            npc = pc_r + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_r <= RESET_PC;
        end else if (!is_stall) begin
            pc_r <= npc;
        end
    end

    // The BTB looks up npc so its answer lines up with pc_r next cycle.
    assign btb_pc       = npc;
    assign btb_is_stall = is_stall;

    assign icache_op        = is_flush ? IC_NOP : IC_R;
    assign icache_idx       = pc_r[11:0];
    assign icache_pa        = pa;
    assign icache_is_cached = mat[0];

    assign pass_out.is_flush = is_flush;
    assign pass_out.pc       = pc_r;
    assign pass_out.btb_pre  = npc;
    assign excp_pass_out     = addr_excp;

    pc_hold_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        is_stall |=> $stable(pc_r)
    ) else $error("fetch1: pc_r moved during stall");

endmodule

/* src/fetch2.sv */
`timescale 1ns/1ps

module fetch2 (
    input  logic                         clk,
    input  logic                         rst_n,
    input  cpu_pkg::fetch1_fetch2_pass_t pass_in,
    input  cpu_pkg::excp_pass_t          excp_in,
    input  cpu_pkg::u32_t                icache_rdata,
    input  logic                         is_stall,
    output cpu_pkg::inst_packet_t        inst_out
);

    import cpu_pkg::*;

    logic                flush_r;
    logic                excp_valid_r;
    fetch1_fetch2_pass_t pass_r;
    excp_pass_t          excp_r;

    // Starts flushed so nothing leaves before the first real fetch.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flush_r      <= 1'b1;
            excp_valid_r <= 1'b0;
        end else if (!is_stall) begin
            flush_r      <= pass_in.is_flush;
            excp_valid_r <= excp_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!is_stall) begin
            pass_r <= pass_in;
            excp_r <= excp_in;
        end
    end

    always_comb begin
        inst_out.valid      = !flush_r;
        inst_out.pc         = pass_r.pc;
        inst_out.pred_npc   = pass_r.btb_pre;
        inst_out.inst       = excp_valid_r ? '0 : icache_rdata; // Faulting fetch has no word.
        inst_out.excp.valid = excp_valid_r;
        inst_out.excp.ecode = excp_r.ecode;
        inst_out.excp.badv  = excp_r.badv;
    end

endmodule

/* src/fetch_front.sv */
`timescale 1ns/1ps

module fetch_front (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cpu_pkg::wr_pc_req_t   ex_wr_pc_req,
    input  cpu_pkg::wr_pc_req_t   excp_wr_pc_req,
    input  cpu_pkg::csr_t         rd_csr,
    input  logic                  is_stall,
    input  logic                  is_flush,
    output cpu_pkg::ic_op_e       icache_op,
    output logic [11:0]           icache_idx,
    output cpu_pkg::phy_t         icache_pa,
    output logic                  icache_is_cached,
    input  cpu_pkg::u32_t         icache_rdata,
    output cpu_pkg::inst_packet_t inst_out
);

    import cpu_pkg::*;

    logic                btb_is_stall;
    u32_t                btb_pc;
    btb_predict_t        btb_predict;
    fetch1_fetch2_pass_t f1_pass;
    excp_pass_t          f1_excp;

    fetch1 u_fetch1 (
        .clk              (clk),
        .rst_n            (rst_n),
        .btb_is_stall     (btb_is_stall),
        .btb_pc           (btb_pc),
        .btb_predict      (btb_predict),
        .ex_wr_pc_req     (ex_wr_pc_req),
        .excp_wr_pc_req   (excp_wr_pc_req),
        .rd_csr           (rd_csr),
        .icache_idx       (icache_idx),
        .icache_op        (icache_op),
        .icache_pa        (icache_pa),
        .icache_is_cached (icache_is_cached),
        .is_stall         (is_stall),
        .is_flush         (is_flush),
        .pass_out         (f1_pass),
        .excp_pass_out    (f1_excp)
    );

    btb u_btb (
        .clk          (clk),
        .rst_n        (rst_n),
        .btb_pc       (btb_pc),
        .btb_is_stall (btb_is_stall),
        .train        (ex_wr_pc_req),          // Execute resolves and trains.
        .btb_predict  (btb_predict)
    );

    fetch2 u_fetch2 (
        .clk          (clk),
        .rst_n        (rst_n),
        .pass_in      (f1_pass),
        .excp_in      (f1_excp),
        .icache_rdata (icache_rdata),
        .is_stall     (is_stall),
        .inst_out     (inst_out)
    );

endmodule

/* tb/front_model.sv */
`timescale 1ns/1ps

module front_model (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cpu_pkg::wr_pc_req_t   ex_req,
    input  cpu_pkg::wr_pc_req_t   excp_req,
    input  cpu_pkg::csr_t         csr,
    input  logic                  stall,
    input  logic                  flush,
    output cpu_pkg::ic_op_e       exp_op,
    output logic [11:0]           exp_idx,
    output cpu_pkg::phy_t         exp_pa,
    output logic                  exp_cached,
    output logic                  exp_mapped,
    output cpu_pkg::inst_packet_t exp_out,
    output int                    pred_hits
);

    import cpu_pkg::*;

    logic ent_v   [BTB_ENTRIES];
    u32_t ent_src [BTB_ENTRIES];                // Whole branch PC stands in for the tag.
    u32_t ent_tgt [BTB_ENTRIES];

    u32_t pc_m;
    logic pred_v;                               // Lookup result that belongs to pc_m.
    u32_t pred_t;
    int   fill_cnt;

    phy_t       cur_pa;
    mat_t       cur_mat;
    excp_pass_t cur_ex;

    task automatic translate(input u32_t va, input csr_t c, output phy_t pa,
                             output mat_t mt, output logic mapped,
                             output excp_pass_t ex);
        logic direct;
        logic hit0;
        logic hit1;
        direct = c.crmd_da && !c.crmd_pg;
        hit0 = ((c.crmd_plv == 2'd0 && c.dmw0.plv0) || (c.crmd_plv == 2'd3 && c.dmw0.plv3))
               && (va[31:29] == c.dmw0.vseg);
        hit1 = ((c.crmd_plv == 2'd0 && c.dmw1.plv0) || (c.crmd_plv == 2'd3 && c.dmw1.plv3))
               && (va[31:29] == c.dmw1.vseg);
        pa     = va;
        mt     = c.crmd_datf;
        mapped = direct || hit0 || hit1;
        if (!direct && hit0) begin
            pa[31:29] = c.dmw0.pseg;
            mt        = c.dmw0.mat;
        end else if (!direct && hit1) begin
            pa[31:29] = c.dmw1.pseg;
            mt        = c.dmw1.mat;
        end
        ex.badv  = va;
        ex.valid = 1'b1;
        if (va[1:0] != 2'b00) begin
            ex.ecode = ECODE_ADEF;
        end else if (!direct && !hit0 && !hit1) begin
            ex.ecode = ECODE_TLBR;              // Paged and outside both windows.
        end else begin
            ex.valid = 1'b0;
            ex.ecode = ECODE_NONE;
        end
    endtask

    // Translation of the PC that is being fetched now.
    always @* begin
        translate(pc_m, csr, cur_pa, cur_mat, exp_mapped, cur_ex);
    end

    assign exp_op     = flush ? IC_NOP : IC_R;
    assign exp_idx    = pc_m[11:0];
    assign exp_pa     = cur_pa;
    assign exp_cached = cur_mat[0];

    always @(posedge clk or negedge rst_n) begin : step
        u32_t       npc;
        btb_idx_t   li;
        btb_idx_t   ti;
        logic       in_fill;
        if (!rst_n) begin
            pc_m      <= RESET_PC;
            pred_v    <= 1'b0;
            pred_t    <= '0;
            fill_cnt  <= 0;
            exp_out   <= '0;
            pred_hits <= 0;
        end else begin
            if (excp_req.valid) begin
                npc = excp_req.pc;
            end else if (ex_req.valid) begin
                npc = ex_req.pc;
            end else if (pred_v) begin
                npc = pred_t;
            end else begin
                npc = pc_m + 32'd4;
            end
            in_fill = (fill_cnt < BTB_ENTRIES);
            li = npc[7:2];
            ti = ex_req.src_pc[7:2];
            if (!stall) begin
                pred_v <= !in_fill && ent_v[li] && (ent_src[li][31:8] == npc[31:8]);
                pred_t <= ent_tgt[li];
                pc_m   <= npc;
                exp_out.valid    <= !flush;
                exp_out.pc       <= pc_m;
                exp_out.pred_npc <= npc;
                exp_out.inst     <= cur_ex.valid ? 32'h0 : (cur_pa ^ 32'ha5a5a5a5);
                exp_out.excp     <= cur_ex;
                if (pred_v && !excp_req.valid && !ex_req.valid) begin
                    pred_hits <= pred_hits + 1;
                end
            end
            if (in_fill) begin
                ent_v[fill_cnt] <= 1'b0;        // Training is ignored until the sweep ends.
                fill_cnt        <= fill_cnt + 1;
            end else if (ex_req.valid && ex_req.taken) begin
                ent_v[ti]   <= 1'b1;
                ent_src[ti] <= ex_req.src_pc;
                ent_tgt[ti] <= ex_req.pc;
            end else if (ex_req.valid && ent_v[ti]
                         && (ent_src[ti][31:8] == ex_req.src_pc[31:8])) begin
                ent_v[ti] <= 1'b0;
            end
        end
    end

endmodule

/* tb/fetch_front_tb.sv */
`timescale 1ns/1ps

module fetch_front_tb;

    import cpu_pkg::*;

    logic         clk;
    logic         rst_n;
    wr_pc_req_t   ex_req;
    wr_pc_req_t   excp_req;
    csr_t         rd_csr;
    logic         is_stall;
    logic         is_flush;
    ic_op_e       icache_op;
    logic [11:0]  icache_idx;
    phy_t         icache_pa;
    logic         icache_is_cached;
    u32_t         icache_rdata = '0;
    inst_packet_t inst_out;
    inst_packet_t exp_out;
    inst_packet_t prev_out;
    int           pred_hits;
    ic_op_e       exp_op;
    logic [11:0]  exp_idx;
    phy_t         exp_pa;
    logic         exp_cached;
    logic         exp_mapped;

    int   err_pc;
    int   err_inst;
    int   err_excp;
    int   err_valid;
    int   err_req;
    int   err_other;
    int   n_adef;
    int   n_tlbr;
    logic stall_prev;                           // Stall level seen by the last edge.
    logic timed_out;

    fetch_front dut_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .ex_wr_pc_req     (ex_req),
        .excp_wr_pc_req   (excp_req),
        .rd_csr           (rd_csr),
        .is_stall         (is_stall),
        .is_flush         (is_flush),
        .icache_op        (icache_op),
        .icache_idx       (icache_idx),
        .icache_pa        (icache_pa),
        .icache_is_cached (icache_is_cached),
        .icache_rdata     (icache_rdata),
        .inst_out         (inst_out)
    );

    front_model model_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_req     (ex_req),
        .excp_req   (excp_req),
        .csr        (rd_csr),
        .stall      (is_stall),
        .flush      (is_flush),
        .exp_op     (exp_op),
        .exp_idx    (exp_idx),
        .exp_pa     (exp_pa),
        .exp_cached (exp_cached),
        .exp_mapped (exp_mapped),
        .exp_out    (exp_out),
        .pred_hits  (pred_hits)
    );

    always #20 clk = ~clk;

    // Cache stand-in with one cycle of latency that repeats its word while stalled.
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            icache_rdata <= '0;
        end else if (icache_op == IC_R && !is_stall) begin
            icache_rdata <= icache_pa ^ 32'ha5a5a5a5;
        end
    end

    function automatic u32_t target_addr(int i);
        // Entries i and i+8 share a BTB index but not a tag.
        return RESET_PC + u32_t'(i % 8) * 32'h84 + u32_t'(i / 8) * 32'h1000;
    endfunction

    function automatic csr_t random_csr();
        csr_t c;
        int   mode;
        c = '0;
        mode = $urandom % 8;
        c.eentry    = target_addr(3);
        c.dmw1.vseg = 3'($urandom);
        c.dmw1.pseg = 3'($urandom);
        c.dmw1.plv0 = 1'b1;
        c.dmw1.mat  = MAT_CC;
        if (mode == 0) begin
            c.crmd_da   = 1'b1;                 // Direct address mode.
            c.crmd_datf = 2'($urandom);
        end else begin
            c.crmd_pg = 1'b1;
            if (mode == 1) begin
                c.dmw0.vseg = 3'd5;             // Neither window covers the code region.
                c.dmw1.vseg = 3'd6;
            end else begin
                c.dmw0.vseg = 3'd0;
                c.dmw0.pseg = 3'($urandom);
                c.dmw0.plv0 = 1'b1;
                c.dmw0.mat  = 2'($urandom);
            end
            if (mode == 7) begin
                c.crmd_plv  = PLV_USER;
                c.dmw0.plv3 = 1'b1;
            end
        end
        return c;
    endfunction

    task automatic check_pc(input string name, input u32_t got, input u32_t want);
        if (got !== want) begin
            $display("[FAIL] %s: got %h, expected %h at %0t", name, got, want, $time);
            err_pc++;
        end
    endtask

    task automatic check_inst(input string name, input u32_t got, input u32_t want);
        if (got !== want) begin
            $display("[FAIL] %s: got %h, expected %h at %0t", name, got, want, $time);
            err_inst++;
        end
    endtask

    task automatic check_excp(input string name, input excp_pass_t got,
                              input excp_pass_t want);
        if (got !== want) begin
            $display("[FAIL] %s: got valid=%h ecode=%h badv=%h, expected valid=%h ecode=%h badv=%h",
                     name, got.valid, got.ecode, got.badv, want.valid, want.ecode, want.badv);
            err_excp++;
        end
    endtask

    task automatic check_valid(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("[FAIL] %s: got %h, expected %h at %0t", name, got, want, $time);
            err_valid++;
        end
    endtask

    // The cached attribute only means something for a mapped address.
    task automatic check_req(input ic_op_e got_op, input logic [11:0] got_idx,
                             input phy_t got_pa, input logic got_cached,
                             input ic_op_e want_op, input logic [11:0] want_idx,
                             input phy_t want_pa, input logic want_cached,
                             input logic mapped);
        if (got_op !== want_op) begin
            $display("[FAIL] icache_op: got %h, expected %h at %0t", got_op, want_op, $time);
            err_req++;
        end
        if (got_idx !== want_idx) begin
            $display("[FAIL] icache_idx: got %h, expected %h at %0t", got_idx, want_idx, $time);
            err_req++;
        end
        if (got_pa !== want_pa) begin
            $display("[FAIL] icache_pa: got %h, expected %h at %0t", got_pa, want_pa, $time);
            err_req++;
        end
        if (mapped && got_cached !== want_cached) begin
            $display("[FAIL] icache_is_cached: got %h, expected %h at %0t",
                     got_cached, want_cached, $time);
            err_req++;
        end
    endtask

    task automatic compare_with_model();
        check_req(icache_op, icache_idx, icache_pa, icache_is_cached,
                  exp_op, exp_idx, exp_pa, exp_cached, exp_mapped);
        check_valid("inst_out.valid", inst_out.valid, exp_out.valid);
        if (exp_out.valid) begin
            check_pc("inst_out.pc", inst_out.pc, exp_out.pc);
            check_pc("inst_out.pred_npc", inst_out.pred_npc, exp_out.pred_npc);
            check_inst("inst_out.inst", inst_out.inst, exp_out.inst);
            check_excp("inst_out.excp", inst_out.excp, exp_out.excp);
        end
        if (inst_out.valid && inst_out.excp.valid) begin
            if (inst_out.excp.ecode == ECODE_ADEF) begin
                n_adef++;
            end else if (inst_out.excp.ecode == ECODE_TLBR) begin
                n_tlbr++;
            end
        end
        if (stall_prev && inst_out !== prev_out) begin
            $display("inst_out changed while the front end was stalled at %0t", $time);
            err_other++;
        end
        prev_out = inst_out;
    endtask

    task automatic drive_random();
        u32_t tgt;
        ex_req   = '0;
        excp_req = '0;
        is_stall = ($urandom % 8) == 0;
        is_flush = ($urandom % 12) == 0;
        if ($urandom % 6 == 0) begin
            tgt = target_addr($urandom % 16);
            if ($urandom % 16 == 0) begin
                tgt[1] = 1'b1;                  // Misaligned target.
            end
            ex_req.valid  = 1'b1;
            ex_req.pc     = tgt;
            ex_req.src_pc = target_addr($urandom % 16);
            ex_req.taken  = ($urandom % 8) != 0;
        end
        if ($urandom % 40 == 0) begin
            excp_req.valid = 1'b1;
            excp_req.pc    = rd_csr.eentry;
            excp_req.taken = 1'b1;
        end
        if ($urandom % 250 == 0) begin
            rd_csr = random_csr();
        end
        stall_prev = is_stall;
    endtask

    initial begin : run
        int waited;
        void'($urandom(32'hf29490c5));
        clk        = 1'b0;
        rst_n      = 1'b0;
        ex_req     = '0;
        excp_req   = '0;
        is_stall   = 1'b0;
        is_flush   = 1'b0;
        rd_csr     = random_csr();
        err_pc     = 0;
        err_inst   = 0;
        err_excp   = 0;
        err_valid  = 0;
        err_req    = 0;
        err_other  = 0;
        n_adef     = 0;
        n_tlbr     = 0;
        stall_prev = 1'b0;
        timed_out  = 1'b0;
        prev_out   = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n  = 1'b1;
        waited = 0;
        while (inst_out.valid !== 1'b1 && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (inst_out.valid !== 1'b1) begin
            $display("Timed out waiting for the first packet after reset");
            err_other++;
            timed_out = 1'b1;
        end else begin
            check_pc("inst_out.pc", inst_out.pc, RESET_PC);
            for (int k = 1; k <= 4; k++) begin
                @(negedge clk);
                check_pc("inst_out.pc", inst_out.pc, RESET_PC + u32_t'(4 * k));
            end
            for (int cyc = 0; cyc < 3000; cyc++) begin
                @(negedge clk);
                compare_with_model();
                drive_random();
            end
            if (n_adef == 0) begin
                $display("No valid packet carried an ADEF exception");
                err_other++;
            end
            if (n_tlbr == 0) begin
                $display("No valid packet carried a TLBR exception");
                err_other++;
            end
            if (pred_hits == 0) begin
                $display("The BTB never supplied a prediction that was followed");
                err_other++;
            end
        end
        $display("Errors: pc %0d, inst %0d, excp %0d, valid %0d, req %0d, other %0d",
                 err_pc, err_inst, err_excp, err_valid, err_req, err_other);
        if (err_pc + err_inst + err_excp + err_valid + err_req + err_other == 0
            && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* fetch_front.f */
src/cpu_pkg.sv
src/addr_trans.sv
src/btb.sv
src/fetch1.sv
src/fetch2.sv
src/fetch_front.sv
tb/front_model.sv
tb/fetch_front_tb.sv
